// ==== Bender.yml ====
package:
  name: mix_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mix_pkg.sv
      - verilog/mix_ctrl_if.sv
      - verilog/mix_state_if.sv
      - verilog/apb_regs.sv
      - verilog/mix_sequencer.sv
      - verilog/round_counter.sv
      - verilog/mix_datapath.sv
      - verilog/mix_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/clk_gen.sv
      - test/mix_tb.sv

// ==== filelist.f ====
+incdir+verilog
verilog/mix_pkg.sv
verilog/mix_ctrl_if.sv
verilog/mix_state_if.sv
verilog/apb_regs.sv
verilog/mix_sequencer.sv
verilog/round_counter.sv
verilog/mix_datapath.sv
verilog/mix_top.sv
test/clk_gen.sv
test/mix_tb.sv

// ==== test/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== test/mix_tb.sv ====
`timescale 1ns/1ns
`include "mix_consts.svh"

module mix_tb;

    localparam int POLL_LIMIT = 200;
    localparam int K_INJECT   = 0;
    localparam int K_LINK     = 1;
    localparam int K_ADDSUB   = 2;
    localparam int K_XORSHIFT = 3;
    localparam int K_SHIFTMIX = 4;
    localparam int K_CHAIN    = 5;
    localparam int K_SCALE    = 6;
    localparam int K_CUBE     = 7;

    localparam int SCALE_MUL [8] = '{2, 3, 5, 7, 11, 13, 17, 19};
    localparam int SCALE_ADD [8] = '{3, 5, 7, 11, 13, 17, 19, 23};
    localparam int CUBE_MUL  [8] = '{2, 3, 3, 3, 5, 13, 35, 87};

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic        exp_err;
    logic        chk_rd;
    logic [31:0] exp_rd;
    int          exp_len;
    int          busy_len;
    int          mismatch_errors;
    int          other_errors;
    integer      seed;
    logic [31:0] ref_words [8];

    clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mix_top mix_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always @(posedge clk) begin
        if (!rst_n || !mix_top_i.busy) busy_len <= 0;
        else busy_len <= busy_len + 1;  // cycles of the running job
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks

    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable |-> pready)
    else begin
        mismatch_errors++;
        $display("Mismatch pready: got %h expected 1", $sampled(pready));
    end

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable |-> pslverr == exp_err)
    else begin
        mismatch_errors++;
        $display("Mismatch pslverr at paddr %h: got %h expected %h",
                 $sampled(paddr), $sampled(pslverr), $sampled(exp_err));
    end

    a_prdata: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable && !pwrite && chk_rd |-> prdata == exp_rd)
    else begin
        mismatch_errors++;
        $display("Mismatch prdata at paddr %h: got %h expected %h",
                 $sampled(paddr), $sampled(prdata), $sampled(exp_rd));
    end

    a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mix_top_i.busy) |-> busy_len == exp_len)
    else begin
        mismatch_errors++;
        $display("Mismatch busy_len: got %h expected %h",
                 $sampled(busy_len), $sampled(exp_len));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model

    task automatic model_step(input int kind);
        for (int i = 0; i < 8; i++) begin
            case (kind)
                K_INJECT:   ref_words[i] = ref_words[i] + i;
                K_LINK:     ref_words[i] = ref_words[i] + ref_words[(i + 7) & 7];
                K_ADDSUB:   ref_words[i] = ref_words[i] + ref_words[(i + 1) & 7]
                                           - ref_words[(i + 5) & 7];
                K_XORSHIFT: ref_words[i] = ref_words[i] ^ (ref_words[(i + 3) & 7] << 16);
                K_SHIFTMIX: ref_words[i] = ref_words[i] - (ref_words[(i + 2) & 7] >> 17)
                                           + (ref_words[(i + 4) & 7] >> 12);
                K_CHAIN:    ref_words[i] = ref_words[i] + ref_words[(i + 7) & 7]
                                           - ref_words[(i + 6) & 7];
                K_SCALE:    ref_words[i] = ref_words[i] * SCALE_MUL[i] + SCALE_ADD[i];
                default:    ref_words[i] = ref_words[i] * CUBE_MUL[i] + i * i * i;
            endcase
        end
    endtask

    task automatic model_job(input int d, input int c);
        model_step(K_INJECT);
        model_step(K_LINK);
        repeat (d) begin
            model_step(K_ADDSUB);
            model_step(K_XORSHIFT);
            model_step(K_SHIFTMIX);
        end
        repeat (c) model_step(K_CHAIN);
        model_step(K_SCALE);
        model_step(K_CUBE);
    endtask

    function automatic logic [31:0] ctrl_word(input int d, input int c, input logic go);
        logic [31:0] dv;
        logic [31:0] cv;
        dv = d;
        cv = c;
        return {11'd0, cv[4:0], 4'd0, dv[3:0], 7'd0, go};
    endfunction

    function automatic logic [7:0] word_addr(input int i);
        return 8'(`MIX_REG_WORD_BASE + i * `MIX_REG_WORD_STRIDE);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus transfers

    task automatic bus_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic err, input logic chk, input logic [31:0] exp,
                            output logic [31:0] rdata);
        @(posedge clk);
        #1;
        psel    = 1'b1;                 // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        exp_err = err;
        chk_rd  = chk;
        exp_rd  = exp;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        chk_rd  = 1'b0;
        exp_err = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
        logic [31:0] unused;
        bus_xfer(1'b1, addr, data, err, 1'b0, '0, unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp, input logic err);
        logic [31:0] unused;
        bus_xfer(1'b0, addr, '0, err, !err, exp, unused);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int polls;
        status = 32'h1;
        polls  = 0;
        while (status[0] && polls < POLL_LIMIT) begin
            bus_xfer(1'b0, `MIX_REG_STATUS, '0, 1'b0, 1'b0, '0, status);
            polls++;
        end
        if (status[0]) begin
            other_errors++;
            $display("Job still busy after %0d status polls", POLL_LIMIT);
        end
    endtask

    task automatic write_seeds();
        logic [31:0] v;
        for (int i = 0; i < 8; i++) begin
            v = $random(seed);
            write_reg(word_addr(i), v, 1'b0);
            ref_words[i] = v;
        end
    endtask

    task automatic check_words();
        for (int i = 0; i < 8; i++) read_reg(word_addr(i), ref_words[i], 1'b0);
    endtask

    task automatic run_job(input int d, input int c);
        exp_len = 2 + 3 * d + c + 2;
        model_job(d, c);
        write_reg(`MIX_REG_CTRL, ctrl_word(d, c, 1'b1), 1'b0);
        wait_idle();
        check_words();
        read_reg(`MIX_REG_STATUS, 32'h2, 1'b0);   // done set
        read_reg(`MIX_REG_STATUS, 32'h2, 1'b0);   // and still set
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus

    initial begin
        int d;
        int c;
        int waits;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        exp_err         = 1'b0;
        chk_rd          = 1'b0;
        exp_rd          = '0;
        exp_len         = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        seed            = 32'hed47;
        for (int i = 0; i < 8; i++) ref_words[i] = i;

        waits = 0;
        while (!rst_n && waits < 20) begin
            @(posedge clk);
            waits++;
        end
        if (!rst_n) begin
            other_errors++;
            $display("Reset never released");
        end

        // reset values
        read_reg(`MIX_REG_STATUS, 32'h0, 1'b0);
        read_reg(`MIX_REG_CTRL, ctrl_word(11, 16, 1'b0), 1'b0);
        check_words();

        run_job(11, 16);                          // defaults on index words

        repeat (4) begin
            d = 1 + ($unsigned($random(seed)) % 15);
            c = 1 + ($unsigned($random(seed)) % 31);
            write_seeds();
            run_job(d, c);
        end

        // transfers rejected while busy
        write_seeds();
        exp_len = 2 + 3 * 3 + 4 + 2;
        model_job(3, 4);
        write_reg(`MIX_REG_CTRL, ctrl_word(3, 4, 1'b1), 1'b0);
        write_reg(word_addr(0), 32'hdead_beef, 1'b1);
        write_reg(`MIX_REG_CTRL, ctrl_word(5, 7, 1'b1), 1'b1);
        read_reg(`MIX_REG_STATUS, 32'h1, 1'b0);   // busy with done cleared
        read_reg(`MIX_REG_CTRL, ctrl_word(3, 4, 1'b0), 1'b0);
        wait_idle();
        check_words();

        // zero round fields
        write_reg(`MIX_REG_CTRL, ctrl_word(0, 5, 1'b1), 1'b1);
        write_reg(`MIX_REG_CTRL, ctrl_word(4, 0, 1'b1), 1'b1);
        read_reg(`MIX_REG_CTRL, ctrl_word(3, 4, 1'b0), 1'b0);
        read_reg(`MIX_REG_STATUS, 32'h2, 1'b0);

        // unmapped offsets
        write_reg(8'h08, 32'h1234_5678, 1'b1);
        read_reg(8'h08, '0, 1'b1);
        write_reg(8'h40, 32'h1234_5678, 1'b1);
        write_reg(8'h22, 32'h1234_5678, 1'b1);
        read_reg(8'hfc, '0, 1'b1);
        check_words();

        run_job(2, 1);                            // done sets again after a start

        @(posedge clk);
        #1;
        $display("Checks done: %0d mismatches, %0d other errors",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/apb_regs.sv ====
`timescale 1ns/1ns
`include "mix_consts.svh"

module apb_regs import mix_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [7:0]   paddr,
    input  word_t        pwdata,
    output word_t        prdata,
    output logic         pready,
    output logic         pslverr,
    input  logic         busy,
    input  logic         done_pulse,
    output logic         start,
    output logic [3:0]   diffuse_rounds,
    output logic [4:0]   chain_rounds,
    mix_state_if.master  st
);

    reg_addr_e  kind;
    logic [7:0] word_off;
    logic [7:0] word_sel;
    logic       access;
    logic       ctrl_err;
    logic       word_err;
    logic       ctrl_wr;
    logic       done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode

    assign access   = psel & penable;
    assign word_off = paddr - `MIX_REG_WORD_BASE;
    assign word_sel = word_off / `MIX_REG_WORD_STRIDE;

    always_comb begin
        if (paddr == `MIX_REG_CTRL) begin
            kind = REG_CTRL;
        end else if (paddr == `MIX_REG_STATUS) begin
            kind = REG_STATUS;
        end else if (paddr >= `MIX_REG_WORD_BASE
                     && word_off < `MIX_WORDS * `MIX_REG_WORD_STRIDE
                     && word_off % `MIX_REG_WORD_STRIDE == 0) begin
            kind = REG_WORD;
        end else begin
            kind = REG_NONE;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write checks

    assign ctrl_err = pwrite && kind == REG_CTRL
                      && (pwdata[11:8] == '0 || pwdata[20:16] == '0 || (pwdata[0] && busy));
    assign word_err = pwrite && kind == REG_WORD && busy;

    assign pready  = 1'b1;                  // no wait states
    assign pslverr = access & (ctrl_err | word_err | (kind == REG_NONE));

    assign ctrl_wr = access && pwrite && kind == REG_CTRL && !ctrl_err;
    assign start   = ctrl_wr & pwdata[0];

    assign st.wr_en = access && pwrite && kind == REG_WORD && !busy;
    assign st.idx   = word_sel[$clog2(`MIX_WORDS)-1:0];
    assign st.wdata = pwdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            diffuse_rounds <= 4'(`MIX_DIFFUSE_DEFAULT);
            chain_rounds   <= 5'(`MIX_CHAIN_DEFAULT);
            done           <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                diffuse_rounds <= pwdata[11:8];
                chain_rounds   <= pwdata[20:16];
            end
            if (start) begin
                done <= 1'b0;
            end else if (done_pulse) begin
                done <= 1'b1;               // sticky until next start
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (kind)
            REG_CTRL: begin
                prdata[11:8]  = diffuse_rounds;
                prdata[20:16] = chain_rounds;
            end
            REG_STATUS: begin
                prdata[0] = busy;
                prdata[1] = done;
            end
            REG_WORD: prdata = st.words[word_sel[$clog2(`MIX_WORDS)-1:0]];
            default:  prdata = '0;
        endcase
    end

endmodule

// ==== verilog/mix_consts.svh ====
`ifndef MIX_CONSTS_SVH
`define MIX_CONSTS_SVH

`define MIX_WORDS            8
`define MIX_XOR_SHIFT        16
`define MIX_SHR_A            17
`define MIX_SHR_B            12

`define MIX_DIFFUSE_DEFAULT  11   // rounds after reset
`define MIX_CHAIN_DEFAULT    16

// first scaling table
`define MIX_SCALE_MUL_0      2
`define MIX_SCALE_MUL_1      3
`define MIX_SCALE_MUL_2      5
`define MIX_SCALE_MUL_3      7
`define MIX_SCALE_MUL_4      11
`define MIX_SCALE_MUL_5      13
`define MIX_SCALE_MUL_6      17
`define MIX_SCALE_MUL_7      19
`define MIX_SCALE_ADD_0      3
`define MIX_SCALE_ADD_1      5
`define MIX_SCALE_ADD_2      7
`define MIX_SCALE_ADD_3      11
`define MIX_SCALE_ADD_4      13
`define MIX_SCALE_ADD_5      17
`define MIX_SCALE_ADD_6      19
`define MIX_SCALE_ADD_7      23

// second scaling table with index cubed as offset
`define MIX_CUBE_MUL_0       2
`define MIX_CUBE_MUL_1       3
`define MIX_CUBE_MUL_2       3
`define MIX_CUBE_MUL_3       3
`define MIX_CUBE_MUL_4       5
`define MIX_CUBE_MUL_5       13
`define MIX_CUBE_MUL_6       35
`define MIX_CUBE_MUL_7       87

`define MIX_REG_CTRL         8'h00
`define MIX_REG_STATUS       8'h04
`define MIX_REG_WORD_BASE    8'h20
`define MIX_REG_WORD_STRIDE  4

`endif

// ==== verilog/mix_ctrl_if.sv ====
`timescale 1ns/1ns

interface mix_ctrl_if import mix_pkg::*; ();

    op_e        op;
    logic       step_en;     // apply op at next edge
    logic       cnt_load;
    logic [4:0] cnt_value;
    logic       cnt_dec;
    logic       cnt_last;    // one round left

    modport sequencer (
        output op, step_en, cnt_load, cnt_value, cnt_dec,
        input  cnt_last
    );

    modport counter (
        input  cnt_load, cnt_value, cnt_dec,
        output cnt_last
    );

    modport datapath (
        input  op, step_en
    );

endinterface

// ==== verilog/mix_datapath.sv ====
`timescale 1ns/1ns
`include "mix_consts.svh"

module mix_datapath import mix_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    mix_ctrl_if.datapath   ctrl,
    mix_state_if.datapath  st
);

    state_t bank;
    state_t bank_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scaling tables

    function automatic word_t scale_mul(int i);
        case (i)
            0:       return `MIX_SCALE_MUL_0;
            1:       return `MIX_SCALE_MUL_1;
            2:       return `MIX_SCALE_MUL_2;
            3:       return `MIX_SCALE_MUL_3;
            4:       return `MIX_SCALE_MUL_4;
            5:       return `MIX_SCALE_MUL_5;
            6:       return `MIX_SCALE_MUL_6;
            default: return `MIX_SCALE_MUL_7;
        endcase
    endfunction

    function automatic word_t scale_add(int i);
        case (i)
            0:       return `MIX_SCALE_ADD_0;
            1:       return `MIX_SCALE_ADD_1;
            2:       return `MIX_SCALE_ADD_2;
            3:       return `MIX_SCALE_ADD_3;
            4:       return `MIX_SCALE_ADD_4;
            5:       return `MIX_SCALE_ADD_5;
            6:       return `MIX_SCALE_ADD_6;
            default: return `MIX_SCALE_ADD_7;
        endcase
    endfunction

    function automatic word_t cube_mul(int i);
        case (i)
            0:       return `MIX_CUBE_MUL_0;
            1:       return `MIX_CUBE_MUL_1;
            2:       return `MIX_CUBE_MUL_2;
            3:       return `MIX_CUBE_MUL_3;
            4:       return `MIX_CUBE_MUL_4;
            5:       return `MIX_CUBE_MUL_5;
            6:       return `MIX_CUBE_MUL_6;
            default: return `MIX_CUBE_MUL_7;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one step where later words see the earlier results

    function automatic state_t mix_step(op_e op, state_t s);
        state_t r;
        r = s;
        for (int i = 0; i < `MIX_WORDS; i++) begin
            case (op)
                OP_INJECT:   r[i] = r[i] + word_t'(i);
                OP_LINK:     r[i] = r[i] + r[(i + `MIX_WORDS - 1) % `MIX_WORDS];
                OP_ADDSUB:   r[i] = r[i] + r[(i + 1) % `MIX_WORDS]
                                    - r[(i + 5) % `MIX_WORDS];
                OP_XORSHIFT: r[i] = r[i] ^ (r[(i + 3) % `MIX_WORDS] << `MIX_XOR_SHIFT);
                OP_SHIFTMIX: r[i] = r[i] - (r[(i + 2) % `MIX_WORDS] >> `MIX_SHR_A)
                                    + (r[(i + 4) % `MIX_WORDS] >> `MIX_SHR_B);
                OP_CHAIN:    r[i] = r[i] + r[(i + `MIX_WORDS - 1) % `MIX_WORDS]
                                    - r[(i + `MIX_WORDS - 2) % `MIX_WORDS];
                OP_SCALE:    r[i] = r[i] * scale_mul(i) + scale_add(i);
                default:     r[i] = r[i] * cube_mul(i) + word_t'(i * i * i);
            endcase
        end
        return r;
    endfunction

    always_comb bank_nxt = mix_step(ctrl.op, bank);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIX_WORDS; i++) begin
                bank[i] <= word_t'(i);          // words start at their index
            end
        end else if (ctrl.step_en) begin
            bank <= bank_nxt;
        end else if (st.wr_en) begin
            bank[st.idx] <= st.wdata;           // seed write while idle
        end
    end

    assign st.words = bank;

endmodule

// ==== verilog/mix_pkg.sv ====
`include "mix_consts.svh"

package mix_pkg;

    typedef logic [31:0] word_t;

    typedef word_t [`MIX_WORDS-1:0] state_t;   // 256 bits

    typedef enum logic [2:0] {
        OP_INJECT,
        OP_LINK,
        OP_ADDSUB,
        OP_XORSHIFT,
        OP_SHIFTMIX,
        OP_CHAIN,
        OP_SCALE,
        OP_CUBE
    } op_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_INJECT,
        PH_LINK,
        PH_DIFFUSE,
        PH_CHAIN,
        PH_SCALE,
        PH_CUBE
    } phase_e;

    typedef enum logic [1:0] {
        REG_CTRL,
        REG_STATUS,
        REG_WORD,
        REG_NONE
    } reg_addr_e;

endpackage

// ==== verilog/mix_sequencer.sv ====
`timescale 1ns/1ns

module mix_sequencer import mix_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [3:0]       diffuse_rounds,
    input  logic [4:0]       chain_rounds,
    output logic             busy,
    output logic             done_pulse,
    mix_ctrl_if.sequencer    ctrl
);

    phase_e     phase;
    phase_e     phase_nxt;
    logic [1:0] sub;          // step inside a diffusion round
    logic [1:0] sub_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
            sub   <= 2'd0;
        end else begin
            phase <= phase_nxt;
            sub   <= sub_nxt;
        end
    end

    assign busy         = (phase != PH_IDLE);
    assign ctrl.step_en = busy;

    always_comb begin
        phase_nxt      = phase;
        sub_nxt        = sub;
        ctrl.op        = OP_INJECT;
        ctrl.cnt_load  = 1'b0;
        ctrl.cnt_value = '0;
        ctrl.cnt_dec   = 1'b0;
        done_pulse     = 1'b0;
        case (phase)
            PH_IDLE: begin
                sub_nxt = 2'd0;
                if (start) phase_nxt = PH_INJECT;
            end
            PH_INJECT: phase_nxt = PH_LINK;
            PH_LINK: begin
                ctrl.op        = OP_LINK;
                ctrl.cnt_load  = 1'b1;
                ctrl.cnt_value = {1'b0, diffuse_rounds};
                phase_nxt      = PH_DIFFUSE;
            end
            PH_DIFFUSE: begin
                case (sub)
                    2'd0:    ctrl.op = OP_ADDSUB;
                    2'd1:    ctrl.op = OP_XORSHIFT;
                    default: ctrl.op = OP_SHIFTMIX;
                endcase
                if (sub == 2'd2) begin
                    sub_nxt = 2'd0;
                    if (ctrl.cnt_last) begin
                        ctrl.cnt_load  = 1'b1;   // chain count for next phase
                        ctrl.cnt_value = chain_rounds;
                        phase_nxt      = PH_CHAIN;
                    end else begin
                        ctrl.cnt_dec = 1'b1;
                    end
                end else begin
                    sub_nxt = sub + 2'd1;
                end
            end
            PH_CHAIN: begin
                ctrl.op = OP_CHAIN;
                if (ctrl.cnt_last) phase_nxt = PH_SCALE;
                else ctrl.cnt_dec = 1'b1;
            end
            PH_SCALE: begin
                ctrl.op   = OP_SCALE;
                phase_nxt = PH_CUBE;
            end
            PH_CUBE: begin
                ctrl.op    = OP_CUBE;
                done_pulse = 1'b1;       // last step of the job
                phase_nxt  = PH_IDLE;
            end
            default: phase_nxt = PH_IDLE;
        endcase
    end

endmodule

// ==== verilog/mix_state_if.sv ====
`timescale 1ns/1ns
`include "mix_consts.svh"

interface mix_state_if import mix_pkg::*; ();

    logic                         wr_en;   // seed write
    logic [$clog2(`MIX_WORDS)-1:0] idx;
    word_t                        wdata;
    state_t                       words;   // live bank contents

    modport master (
        output wr_en, idx, wdata,
        input  words
    );

    modport datapath (
        input  wr_en, idx, wdata,
        output words
    );

endinterface

// ==== verilog/mix_top.sv ====
`timescale 1ns/1ns

module mix_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic       start;
    logic [3:0] diffuse_rounds;
    logic [4:0] chain_rounds;
    logic       busy;
    logic       done_pulse;

    mix_ctrl_if  ctrl_if ();
    mix_state_if state_if ();

    apb_regs apb_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .busy           (busy),
        .done_pulse     (done_pulse),
        .start          (start),
        .diffuse_rounds (diffuse_rounds),
        .chain_rounds   (chain_rounds),
        .st             (state_if.master)
    );

    mix_sequencer mix_sequencer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .diffuse_rounds (diffuse_rounds),
        .chain_rounds   (chain_rounds),
        .busy           (busy),
        .done_pulse     (done_pulse),
        .ctrl           (ctrl_if.sequencer)
    );

    round_counter round_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl_if.counter)
    );

    mix_datapath mix_datapath_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl_if.datapath),
        .st    (state_if.datapath)
    );

endmodule

// ==== verilog/round_counter.sv ====
`timescale 1ns/1ns

module round_counter (
    input  logic          clk,
    input  logic          rst_n,
    mix_ctrl_if.counter   ctrl
);

    logic [4:0] remaining;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= 5'd0;
        end else if (ctrl.cnt_load) begin
            remaining <= ctrl.cnt_value;     // load wins over decrement
        end else if (ctrl.cnt_dec) begin
            remaining <= remaining - 5'd1;
        end
    end

    assign ctrl.cnt_last = (remaining == 5'd1);

endmodule
